// ==== hw/display_macros.svh ====
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// Matrix geometry.
`define PIXEL_WIDTH     4
`define PIXEL_HEIGHT    3
`define BYTES_PER_PIXEL 3   // One byte per colour.

`define FRAME_BYTES (`PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL)

// Counter widths, never below one bit.
`define ROW_BITS    ((`PIXEL_HEIGHT > 1) ? $clog2(`PIXEL_HEIGHT) : 1)
`define COLUMN_BITS ((`PIXEL_WIDTH > 1) ? $clog2(`PIXEL_WIDTH) : 1)
`define PIXEL_BITS  ((`BYTES_PER_PIXEL > 1) ? $clog2(`BYTES_PER_PIXEL) : 1)

// Byte address into the frame buffer.
`define ADDR_BITS   ($clog2(`FRAME_BYTES))

`endif

// ==== hw/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // First byte of every host command.
    typedef enum logic [7:0] {
        CMD_NOP        = 8'h00,
        CMD_READFRAME  = 8'h01,
        CMD_BRIGHTNESS = 8'h02,
        CMD_SCAN       = 8'h03
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        DISPATCH_IDLE,
        DISPATCH_FRAME,
        DISPATCH_BRIGHTNESS
    } dispatch_state_e;

    typedef enum logic [1:0] {
        LOADER_PRIME,
        LOADER_READ,
        LOADER_DONE
    } loader_state_e;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_e;

endpackage

`default_nettype wire

// ==== hw/cmd_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "display_macros.svh"

module cmd_dispatch
    import display_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] data_in,
    input  wire        data_valid,
    input  wire        frame_loaded,
    input  wire        scan_busy,
    output logic       loader_enable,
    output logic       scan_start,
    output logic [7:0] brightness,
    output logic       loading
);

    dispatch_state_e state;
    cmd_opcode_e     opcode;
    logic            decode;

    assign opcode = cmd_opcode_e'(data_in);

    // The cycle of the loader's done pulse is already free for a new opcode.
    assign decode = data_valid &&
                    ((state == DISPATCH_IDLE) || (state == DISPATCH_FRAME && frame_loaded));

    assign loader_enable = data_valid && (state == DISPATCH_FRAME) && !frame_loaded;
    assign loading       = (state == DISPATCH_FRAME);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= DISPATCH_IDLE;
            brightness <= 8'hff;    // Full scale.
            scan_start <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            case (state)
                DISPATCH_FRAME: begin
                    if (frame_loaded) begin
                        state <= DISPATCH_IDLE;
                    end
                end
                DISPATCH_BRIGHTNESS: begin
                    if (data_valid) begin
                        brightness <= data_in;
                        state      <= DISPATCH_IDLE;
                    end
                end
                default: ;
            endcase

            if (decode) begin
                case (opcode)
                    CMD_READFRAME:  state <= DISPATCH_FRAME;
                    CMD_BRIGHTNESS: state <= DISPATCH_BRIGHTNESS;
                    CMD_SCAN:       scan_start <= !scan_busy;   // Dropped mid-scan.
                    default: ;                                  // NOP and unknown codes.
                endcase
            end
        end
    end

    // Loader only finishes a frame that was handed to it.
    assert property (@(posedge clk) disable iff (reset)
        frame_loaded |-> state == DISPATCH_FRAME);

endmodule

`default_nettype wire

// ==== hw/frame_loader.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "display_macros.svh"

module frame_loader
    import display_pkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [7:0]              data_in,
    input  wire                     enable,
    output logic [`ROW_BITS-1:0]    row,
    output logic [`COLUMN_BITS-1:0] column,
    output logic [`PIXEL_BITS-1:0]  pixel,
    output logic [7:0]              data_out,
    output logic                    ram_write_enable,
    output logic                    ram_access_start,
    output logic                    done
);

    loader_state_e           state;
    logic [`ROW_BITS-1:0]    row_next;
    logic [`COLUMN_BITS-1:0] column_next;
    logic [`PIXEL_BITS-1:0]  pixel_next;
    logic                    last_byte;
    logic                    take_byte;

    assign take_byte = enable && (state != LOADER_DONE);

    // Pixel first, then column, then row, all counting down.
    always_comb begin
        row_next    = row;
        column_next = column;
        pixel_next  = pixel - 1'b1;
        if (pixel == '0) begin
            pixel_next = (`PIXEL_BITS)'(`BYTES_PER_PIXEL - 1);
            if (column == '0) begin
                column_next = (`COLUMN_BITS)'(`PIXEL_WIDTH - 1);
                row_next    = row - 1'b1;
            end else begin
                column_next = column - 1'b1;
            end
        end
    end

    assign last_byte = (row_next == '0) && (column_next == '0) && (pixel_next == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= LOADER_PRIME;
            row              <= '0;
            column           <= '0;
            pixel            <= '0;
            ram_write_enable <= 1'b0;
            ram_access_start <= 1'b0;
            done             <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LOADER_PRIME: begin
                    if (enable) begin
                        // First byte goes to the top corner.
                        row              <= (`ROW_BITS)'(`PIXEL_HEIGHT - 1);
                        column           <= (`COLUMN_BITS)'(`PIXEL_WIDTH - 1);
                        pixel            <= (`PIXEL_BITS)'(`BYTES_PER_PIXEL - 1);
                        ram_write_enable <= 1'b1;
                        ram_access_start <= !ram_access_start;
                        state            <= LOADER_READ;
                    end
                end
                LOADER_READ: begin
                    if (enable) begin
                        row              <= row_next;
                        column           <= column_next;
                        pixel            <= pixel_next;
                        ram_access_start <= !ram_access_start;
                        if (last_byte) begin
                            done  <= 1'b1;
                            state <= LOADER_DONE;
                        end
                    end
                end
                default: begin
                    // Address 0 is being written this cycle.
                    ram_write_enable <= 1'b0;
                    state            <= LOADER_PRIME;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte) begin
            data_out <= data_in;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        row < `PIXEL_HEIGHT && column < `PIXEL_WIDTH && pixel < `BYTES_PER_PIXEL);

endmodule

`default_nettype wire

// ==== hw/frame_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "display_macros.svh"

module frame_buffer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [`ROW_BITS-1:0]    row,
    input  wire  [`COLUMN_BITS-1:0] column,
    input  wire  [`PIXEL_BITS-1:0]  pixel,
    input  wire  [7:0]              wr_data,
    input  wire                     write_enable,
    input  wire                     access_start,
    input  wire  [`ADDR_BITS-1:0]   rd_addr,
    output logic [7:0]              rd_data
);

    logic [7:0]            mem [`FRAME_BYTES];
    logic                  toggle_q;
    logic                  write_fire;
    logic [`ADDR_BITS-1:0] wr_addr;

    // Row-major byte index.
    assign wr_addr = (`ADDR_BITS)'((row * `PIXEL_WIDTH + column) * `BYTES_PER_PIXEL + pixel);

    assign write_fire = write_enable && (access_start != toggle_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            toggle_q <= 1'b0;
        end else begin
            toggle_q <= access_start;
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // One cycle read latency.
    end

    assert property (@(posedge clk) disable iff (reset)
        write_fire |-> wr_addr < `FRAME_BYTES);

    // The loader never moves the strobe with writes switched off.
    assert property (@(posedge clk) disable iff (reset)
        (access_start != toggle_q) |-> write_enable);

endmodule

`default_nettype wire

// ==== hw/frame_scanout.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "display_macros.svh"

module frame_scanout
    import display_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   scan_start,
    input  wire  [7:0]            brightness,
    input  wire  [7:0]            rd_data,
    output logic [`ADDR_BITS-1:0] rd_addr,
    output logic [7:0]            scan_data,
    output logic                  scan_valid,
    output logic                  scan_done,
    output logic                  scan_busy
);

    scan_state_e state;
    logic        last_addr;
    logic [15:0] product;

    assign last_addr = (rd_addr == (`ADDR_BITS)'(`FRAME_BYTES - 1));

    // Upper byte of the scaled value.
    assign product   = rd_data * brightness;
    assign scan_data = product[15:8];

    // Covers the byte still in the RAM pipeline.
    assign scan_busy = (state == SCAN_RUN) || scan_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SCAN_IDLE;
            rd_addr    <= '0;
            scan_valid <= 1'b0;
            scan_done  <= 1'b0;
        end else begin
            scan_valid <= (state == SCAN_RUN);  // Matches rd_data.
            scan_done  <= (state == SCAN_RUN) && last_addr;
            case (state)
                SCAN_IDLE: begin
                    if (scan_start) begin
                        rd_addr <= '0;
                        state   <= SCAN_RUN;
                    end
                end
                default: begin
                    if (last_addr) begin
                        state <= SCAN_IDLE;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
            endcase
        end
    end

    // In idle, valid only lingers for the final byte of the frame.
    assert property (@(posedge clk) disable iff (reset)
        (state == SCAN_IDLE && scan_valid) |-> scan_done);

endmodule

`default_nettype wire

// ==== hw/display_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "display_macros.svh"

module display_ctrl_top (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] data_in,
    input  wire        data_valid,
    output logic [7:0] scan_data,
    output logic       scan_valid,
    output logic       scan_done,
    output logic       frame_done,
    output logic       busy
);

    logic                    loader_enable;
    logic                    scan_start;
    logic [7:0]              brightness;
    logic                    loading;
    logic                    scan_busy;
    logic [`ROW_BITS-1:0]    row;
    logic [`COLUMN_BITS-1:0] column;
    logic [`PIXEL_BITS-1:0]  pixel;
    logic [7:0]              wr_data;
    logic                    ram_write_enable;
    logic                    ram_access_start;
    logic [`ADDR_BITS-1:0]   rd_addr;
    logic [7:0]              rd_data;

    assign busy = loading || scan_busy;

    cmd_dispatch u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in),
        .data_valid    (data_valid),
        .frame_loaded  (frame_done),   // Same pulse ends the frame command.
        .scan_busy     (scan_busy),
        .loader_enable (loader_enable),
        .scan_start    (scan_start),
        .brightness    (brightness),
        .loading       (loading)
    );

    frame_loader u_loader (
        .clk              (clk),
        .reset            (reset),
        .data_in          (data_in),
        .enable           (loader_enable),
        .row              (row),
        .column           (column),
        .pixel            (pixel),
        .data_out         (wr_data),
        .ram_write_enable (ram_write_enable),
        .ram_access_start (ram_access_start),
        .done             (frame_done)
    );

    frame_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .row          (row),
        .column       (column),
        .pixel        (pixel),
        .wr_data      (wr_data),
        .write_enable (ram_write_enable),
        .access_start (ram_access_start),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    frame_scanout u_scanout (
        .clk        (clk),
        .reset      (reset),
        .scan_start (scan_start),
        .brightness (brightness),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .scan_data  (scan_data),
        .scan_valid (scan_valid),
        .scan_done  (scan_done),
        .scan_busy  (scan_busy)
    );

endmodule

`default_nettype wire

// ==== verif/display_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "display_macros.svh"

module display_ctrl_tb
    import display_pkg::*;
();

    localparam int NUM_STEPS = 13;

    logic       clk;
    logic       reset;
    logic [7:0] data_in;
    logic       data_valid;
    logic [7:0] scan_data;
    logic       scan_valid;
    logic       scan_done;
    logic       frame_done;
    logic       busy;

    // Command table and what each scan should return.
    logic [7:0] step_op [NUM_STEPS];
    logic [7:0] step_arg [NUM_STEPS];   // Frame index, level, or second-scan flag.
    bit         step_gaps [NUM_STEPS];
    int         step_exp_frame [NUM_STEPS];
    logic [7:0] step_exp_bright [NUM_STEPS];

    logic [7:0] frames [2][`FRAME_BYTES];
    logic [7:0] got_q[$];
    int         valid_cycle_q[$];
    int         seed = 15;
    int         cycle = 0;
    int         error_count = 0;
    int         done_count = 0;
    int         done_cycle = 0;
    int         scan_done_count = 0;
    int         scan_done_cycle = 0;
    int         bytes_at_done = 0;

    display_ctrl_top uut (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .data_valid (data_valid),
        .scan_data  (scan_data),
        .scan_valid (scan_valid),
        .scan_done  (scan_done),
        .frame_done (frame_done),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (!reset) begin
            if (frame_done) begin
                done_count++;
                done_cycle = cycle;
            end
            if (scan_valid) begin
                got_q.push_back(scan_data);
                valid_cycle_q.push_back(cycle);
                check_flag("busy during scan", busy, 1'b1);
            end
            if (scan_done) begin
                scan_done_count++;
                scan_done_cycle = cycle;
                bytes_at_done   = got_q.size();
            end
        end
    end

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int index);
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0t ns: scan byte %0d is %02h, expected %02h",
                     $time, index, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_pulse(input string name, input int count, input int got_cycle,
                               input int exp_cycle);
        if (count != 1) begin
            error_count++;
            $display("FAIL at %0t ns: %s pulsed %0d times, expected once", $time, name, count);
            report_failure();
        end else if (got_cycle != exp_cycle) begin
            error_count++;
            $display("FAIL at %0t ns: %s in cycle %0d, expected cycle %0d",
                     $time, name, got_cycle, exp_cycle);
            report_failure();
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(posedge clk);
        #1;
        data_in    = value;
        data_valid = 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        data_in    = 8'h00;
        data_valid = 1'b0;
    endtask

    task automatic add_step(input int i, input logic [7:0] op, input logic [7:0] arg,
                            input bit gaps, input int exp_frame, input logic [7:0] exp_bright);
        step_op[i]         = op;
        step_arg[i]        = arg;
        step_gaps[i]       = gaps;
        step_exp_frame[i]  = exp_frame;
        step_exp_bright[i] = exp_bright;
    endtask

    task automatic load_frame(input int f, input bit gaps);
        int k;
        int gap;
        int last_cycle;
        int waited;
        int done_before;
        done_before = done_count;
        send_byte(CMD_READFRAME);
        for (k = 0; k < `FRAME_BYTES; k++) begin
            if (gaps) begin
                gap = $random(seed) & 3;
                repeat (gap) idle_cycle();
            end
            send_byte(frames[f][k]);
            check_flag("busy during frame load", busy, 1'b1);
        end
        last_cycle = cycle;
        idle_cycle();
        waited = 0;
        while (done_count == done_before) begin
            if (waited == 20) begin
                $display("Timeout: frame_done never pulsed after the last frame byte");
                report_failure();
            end
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);    // Room for a stray second pulse.
        #1;
        check_pulse("frame_done", done_count - done_before, done_cycle, last_cycle + 1);
        check_flag("busy after frame load", busy, 1'b0);
    endtask

    task automatic set_brightness(input logic [7:0] level);
        send_byte(CMD_BRIGHTNESS);
        send_byte(level);
        idle_cycle();
    endtask

    task automatic send_lone_opcode(input logic [7:0] op);
        send_byte(op);
        idle_cycle();
        idle_cycle();
        check_flag("busy after lone opcode", busy, 1'b0);
    endtask

    task automatic run_scan(input bit second, input int f, input logic [7:0] bright);
        int a;
        int base;
        int scans_before;
        int start_cycle;
        int waited;
        logic [15:0] scaled;
        base         = got_q.size();
        scans_before = scan_done_count;
        send_byte(CMD_SCAN);
        start_cycle = cycle;
        idle_cycle();
        if (second) begin
            repeat (3) idle_cycle();
            send_byte(CMD_SCAN);      // Lands mid-scan.
            idle_cycle();
        end
        waited = 0;
        while (scan_done_count == scans_before) begin
            if (waited == 100) begin
                $display("Timeout: scan_done never pulsed after the scan command");
                report_failure();
            end
            @(posedge clk);
            waited++;
        end
        repeat (8) @(posedge clk);
        #1;
        check_flag("busy after scan", busy, 1'b0);
        check_count("scan byte count", got_q.size() - base, `FRAME_BYTES);
        check_count("bytes seen at scan_done", bytes_at_done - base, `FRAME_BYTES);
        check_count("first scan_valid cycle", valid_cycle_q[base], start_cycle + 3);
        check_pulse("scan_done", scan_done_count - scans_before, scan_done_cycle,
                    start_cycle + 2 + `FRAME_BYTES);
        // Address a holds send-order byte FRAME_BYTES-1-a.
        for (a = 0; a < `FRAME_BYTES; a++) begin
            scaled = 16'(frames[f][`FRAME_BYTES - 1 - a]) * 16'(bright);
            check_byte(got_q[base + a], scaled[15:8], a);
        end
    endtask

    initial begin
        int i;
        int k;
        reset      = 1'b1;
        data_in    = 8'h00;
        data_valid = 1'b0;
        for (i = 0; i < 2; i++) begin
            for (k = 0; k < `FRAME_BYTES; k++) begin
                frames[i][k] = 8'($random(seed));
            end
        end
        add_step(0,  CMD_READFRAME,  8'd0,   1'b0, 0, 8'h00);
        add_step(1,  CMD_SCAN,       8'd0,   1'b0, 0, 8'hff);
        add_step(2,  CMD_BRIGHTNESS, 8'h80,  1'b0, 0, 8'h00);
        add_step(3,  CMD_SCAN,       8'd0,   1'b0, 0, 8'h80);
        add_step(4,  CMD_READFRAME,  8'd1,   1'b0, 0, 8'h00);
        add_step(5,  CMD_SCAN,       8'd0,   1'b0, 1, 8'h80);
        add_step(6,  CMD_BRIGHTNESS, 8'hff,  1'b0, 0, 8'h00);
        add_step(7,  CMD_READFRAME,  8'd0,   1'b1, 0, 8'h00);
        add_step(8,  CMD_SCAN,       8'd0,   1'b0, 0, 8'hff);
        add_step(9,  CMD_NOP,        8'd0,   1'b0, 0, 8'h00);
        add_step(10, 8'h7e,          8'd0,   1'b0, 0, 8'h00);   // Unknown opcode.
        add_step(11, CMD_SCAN,       8'd0,   1'b0, 0, 8'hff);
        add_step(12, CMD_SCAN,       8'd1,   1'b0, 0, 8'hff);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < NUM_STEPS; i++) begin
            case (step_op[i])
                CMD_READFRAME:  load_frame(int'(step_arg[i]), step_gaps[i]);
                CMD_BRIGHTNESS: set_brightness(step_arg[i]);
                CMD_SCAN:       run_scan(step_arg[i][0], step_exp_frame[i], step_exp_bright[i]);
                default:        send_lone_opcode(step_op[i]);
            endcase
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/display_pkg.sv
hw/cmd_dispatch.sv
hw/frame_loader.sv
hw/frame_buffer.sv
hw/frame_scanout.sv
hw/display_ctrl_top.sv
verif/display_ctrl_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module display_ctrl_tb \
		-Mdir obj_dir -o display_sim
	./obj_dir/display_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
